/* hw/ex_pkg.sv */
package ex_pkg;

    // datapath and slot geometry
    localparam int XLEN        = 32;
    localparam int NUM_SLOTS   = 4;
    localparam int SHAMT_W     = 5;
    localparam int PHYS_TAG_W  = 6;
    localparam int RS_IDX_W    = 2;
    localparam int ROB_IDX_W   = 5;
    localparam int SLOT_IDX_W  = $clog2(NUM_SLOTS);

    // ALUs take SLOT_ALU_LO and every slot above it
    localparam int SLOT_LOAD   = 0;
    localparam int SLOT_BRANCH = 1;
    localparam int SLOT_ALU_LO = 2;

    // branch condition codes
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // funct3 bit that marks LBU/LHU
    localparam int F3_UNSIGNED_BIT = 2;

    localparam logic [XLEN-1:0] ALU_FILLER = 32'hbad0c0de;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [PHYS_TAG_W-1:0] phys_tag_t;
    typedef logic [RS_IDX_W-1:0]   rs_idx_t;
    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;
    typedef logic [SLOT_IDX_W-1:0] slot_idx_t;
    typedef logic [2:0]            funct3_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_AND  = 4'h2,
        ALU_OR   = 4'h3,
        ALU_XOR  = 4'h4,
        ALU_SLT  = 4'h5,
        ALU_SLTU = 4'h6,
        ALU_SLL  = 4'h7,
        ALU_SRL  = 4'h8,
        ALU_SRA  = 4'h9
    } alu_func_e;

    // matches funct3[1:0] of the load instruction
    typedef enum logic [1:0] {
        MEM_BYTE = 2'h0,
        MEM_HALF = 2'h1,
        MEM_WORD = 2'h2
    } mem_size_e;

    typedef enum logic [1:0] {
        BUS_NONE = 2'h0,
        BUS_LOAD = 2'h1
    } bus_cmd_e;

    typedef struct packed {
        logic      valid;
        xlen_t     opa;
        xlen_t     opb;
        xlen_t     rs1_value;
        xlen_t     rs2_value;
        alu_func_e alu_func;
        funct3_t   funct3;
        logic      rd_mem;
        logic      cond_branch;
        logic      uncond_branch;
        logic      pred_take;
        xlen_t     npc;
        phys_tag_t dest_tag;
        rs_idx_t   rs_idx;
        rob_idx_t  rob_idx;
        logic      illegal;
    } issue_pkt_t;

    typedef issue_pkt_t [NUM_SLOTS-1:0] issue_vec_t;

    typedef struct packed {
        logic      valid;
        xlen_t     result;
        logic      write_en;
        phys_tag_t write_tag;
        xlen_t     write_data;
        logic      remove_en;
        rs_idx_t   rs_idx;
        rob_idx_t  rob_idx;
        logic      take_branch;
        logic      cond_take;
        logic      bp_enable;
    } fu_result_t;

    typedef struct packed {
        slot_idx_t  slot;
        fu_result_t fu;
    } complete_t;

    typedef struct packed {
        bus_cmd_e  cmd;
        mem_size_e size;
        xlen_t     addr;
    } dmem_req_t;

endpackage

/* hw/alu_unit.sv */
`timescale 1ns/1ns

module alu_unit (
    input  ex_pkg::issue_pkt_t pkt,
    output ex_pkg::fu_result_t res
);
    import ex_pkg::*;

    logic signed [XLEN-1:0] s_opa;
    logic signed [XLEN-1:0] s_opb;
    logic [SHAMT_W-1:0]     shamt;
    xlen_t                  alu_out;

    assign s_opa = pkt.opa;
    assign s_opb = pkt.opb;
    assign shamt = pkt.opb[SHAMT_W-1:0];

    always_comb begin
        case (pkt.alu_func)
            ALU_ADD:  alu_out = pkt.opa + pkt.opb;
            ALU_SUB:  alu_out = pkt.opa - pkt.opb;
            ALU_AND:  alu_out = pkt.opa & pkt.opb;
            ALU_OR:   alu_out = pkt.opa | pkt.opb;
            ALU_XOR:  alu_out = pkt.opa ^ pkt.opb;
            ALU_SLT:  alu_out = xlen_t'(s_opa < s_opb);
            ALU_SLTU: alu_out = xlen_t'(pkt.opa < pkt.opb);
            ALU_SLL:  alu_out = pkt.opa << shamt;
            ALU_SRL:  alu_out = pkt.opa >> shamt;
            ALU_SRA:  alu_out = xlen_t'(s_opa >>> shamt);
            default:  alu_out = ALU_FILLER;
        endcase
    end

    // ALUs never redirect fetch or train the predictor
    assign res.valid       = pkt.valid;
    assign res.result      = alu_out;
    assign res.write_en    = pkt.valid && !pkt.illegal && (pkt.dest_tag != '0);
    assign res.write_tag   = pkt.dest_tag;
    assign res.write_data  = alu_out;
    assign res.remove_en   = pkt.valid && !pkt.illegal;
    assign res.rs_idx      = pkt.rs_idx;
    assign res.rob_idx     = pkt.rob_idx;
    assign res.take_branch = 1'b0;
    assign res.cond_take   = 1'b0;
    assign res.bp_enable   = 1'b0;

    // decode upstream must only send ALU codes to these slots
    always_comb begin
        if (pkt.valid) begin
            assert (pkt.alu_func inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                                         ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA})
                else $error("alu_unit: unknown alu_func %0h", pkt.alu_func);
        end
    end

endmodule

/* hw/branch_unit.sv */
`timescale 1ns/1ns

module branch_unit (
    input  ex_pkg::issue_pkt_t pkt,
    output ex_pkg::fu_result_t res
);
    import ex_pkg::*;

    logic signed [XLEN-1:0] s_rs1;
    logic signed [XLEN-1:0] s_rs2;
    logic                   take_cond;
    logic                   take_branch;
    logic                   live;
    xlen_t                  target;
    xlen_t                  br_result;

    assign s_rs1 = pkt.rs1_value;
    assign s_rs2 = pkt.rs2_value;

    always_comb begin
        case (pkt.funct3)
            F3_BEQ:  take_cond = (pkt.rs1_value == pkt.rs2_value);
            F3_BNE:  take_cond = (pkt.rs1_value != pkt.rs2_value);
            F3_BLT:  take_cond = (s_rs1 < s_rs2);
            F3_BGE:  take_cond = (s_rs1 >= s_rs2);
            F3_BLTU: take_cond = (pkt.rs1_value < pkt.rs2_value);
            F3_BGEU: take_cond = (pkt.rs1_value >= pkt.rs2_value);
            default: take_cond = 1'b0;
        endcase
    end

    assign live   = pkt.valid && !pkt.illegal;
    assign target = pkt.opa + pkt.opb;

    // redirect on jumps, or when the predictor guessed wrong
    assign take_branch = pkt.uncond_branch || (pkt.cond_branch && (take_cond ^ pkt.pred_take));

    // predicted taken but falls through: fetch must resume at npc
    assign br_result = (pkt.cond_branch && pkt.pred_take && !take_cond) ? pkt.npc : target;

    assign res.valid       = pkt.valid;
    assign res.result      = br_result;
    assign res.write_en    = live && (pkt.dest_tag != '0);
    assign res.write_tag   = pkt.dest_tag;
    // link value for jal/jalr
    assign res.write_data  = take_branch ? pkt.npc : br_result;
    // a redirect flushes the entry instead of releasing it
    assign res.remove_en   = live && !take_branch;
    assign res.rs_idx      = pkt.rs_idx;
    assign res.rob_idx     = pkt.rob_idx;
    assign res.take_branch = take_branch;

    // predictor training for the fetch stage
    assign res.cond_take   = live && take_cond;
    assign res.bp_enable   = live && pkt.cond_branch;

endmodule

/* hw/load_unit.sv */
`timescale 1ns/1ns

module load_unit (
    input  ex_pkg::issue_pkt_t pkt,
    input  ex_pkg::xlen_t      dmem_rdata,
    output ex_pkg::dmem_req_t  dmem_req,
    output ex_pkg::fu_result_t res
);
    import ex_pkg::*;

    xlen_t     addr;
    mem_size_e size;
    logic      rd_unsigned;
    xlen_t     load_data;
    xlen_t     ld_result;

    assign addr        = pkt.opa + pkt.opb;
    assign size        = mem_size_e'(pkt.funct3[1:0]);
    assign rd_unsigned = pkt.funct3[F3_UNSIGNED_BIT];

    assign dmem_req.cmd  = (pkt.valid && pkt.rd_mem) ? BUS_LOAD : BUS_NONE;
    assign dmem_req.size = size;
    assign dmem_req.addr = addr;

    // narrow loads come back in the low bits
    always_comb begin
        load_data = dmem_rdata;
        case (size)
            MEM_BYTE: begin
                if (rd_unsigned) begin
                    load_data[XLEN-1:8] = '0;
                end else begin
                    load_data[XLEN-1:8] = {(XLEN-8){dmem_rdata[7]}};
                end
            end
            MEM_HALF: begin
                if (rd_unsigned) begin
                    load_data[XLEN-1:16] = '0;
                end else begin
                    load_data[XLEN-1:16] = {(XLEN-16){dmem_rdata[15]}};
                end
            end
            default: load_data = dmem_rdata;
        endcase
    end

    // without rd_mem the slot only yields the effective address
    assign ld_result = pkt.rd_mem ? load_data : addr;

    assign res.valid       = pkt.valid;
    assign res.result      = ld_result;
    assign res.write_en    = pkt.valid && !pkt.illegal && (pkt.dest_tag != '0);
    assign res.write_tag   = pkt.dest_tag;
    assign res.write_data  = ld_result;
    assign res.remove_en   = pkt.valid && !pkt.illegal && pkt.rd_mem;
    assign res.rs_idx      = pkt.rs_idx;
    assign res.rob_idx     = pkt.rob_idx;
    assign res.take_branch = 1'b0;
    assign res.cond_take   = 1'b0;
    assign res.bp_enable   = 1'b0;

endmodule

/* hw/complete_select.sv */
`timescale 1ns/1ns

module complete_select (
    input  logic               clock,
    input  logic               rst,
    input  ex_pkg::fu_result_t fu_res [ex_pkg::NUM_SLOTS],
    output ex_pkg::complete_t  complete
);
    import ex_pkg::*;

    complete_t sel;

    // scan high to low so the lowest valid slot is the last to win
    always_comb begin
        sel = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (fu_res[i].valid) begin
                sel.fu   = fu_res[i];
                sel.slot = slot_idx_t'(i);
            end
        end
    end

    // one completion per cycle, losers stay in the RS
    always_ff @(posedge clock) begin
        if (rst) begin
            complete <= '0;
        end else begin
            complete <= sel;
        end
    end

    // a register write always belongs to a live record with a real tag
    assert property (@(posedge clock) disable iff (rst)
        complete.fu.write_en |-> (complete.fu.valid && (complete.fu.write_tag != '0)))
        else $error("complete_select: write_en on invalid record or tag 0");

    // RS release only for a live record
    assert property (@(posedge clock) disable iff (rst)
        complete.fu.remove_en |-> complete.fu.valid)
        else $error("complete_select: remove_en without valid");

endmodule

/* hw/stage_ex.sv */
`timescale 1ns/1ns

module stage_ex (
    input  logic              clock,
    input  logic              rst,
    input  ex_pkg::issue_vec_t issue,
    input  ex_pkg::xlen_t     dmem_rdata,
    output ex_pkg::dmem_req_t dmem_req,
    output ex_pkg::complete_t complete
);
    import ex_pkg::*;

    // one result per issue slot, indexed by slot number
    fu_result_t fu_res [NUM_SLOTS];

    // integer ALUs on the upper slots
    for (genvar i = SLOT_ALU_LO; i < NUM_SLOTS; i++) begin : g_alu
        alu_unit u_alu (
            .pkt (issue[i]),
            .res (fu_res[i])
        );
    end

    branch_unit u_branch (
        .pkt (issue[SLOT_BRANCH]),
        .res (fu_res[SLOT_BRANCH])
    );

    load_unit u_load (
        .pkt        (issue[SLOT_LOAD]),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (dmem_req),
        .res        (fu_res[SLOT_LOAD])
    );

    complete_select u_select (
        .clock    (clock),
        .rst      (rst),
        .fu_res   (fu_res),
        .complete (complete)
    );

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clock,
    output logic rst
);
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 10;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
    end

endmodule

/* sim/tb_stage_ex.sv */
`timescale 1ns/1ns

module tb_stage_ex;
    import ex_pkg::*;

    logic       clock;
    logic       rst;
    issue_vec_t issue;
    xlen_t      dmem_rdata;
    dmem_req_t  dmem_req;
    complete_t  complete;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          timeouts;
    int          checked;
    bit          have_exp;
    complete_t   exp_prev;

    tb_clock_gen u_clock_gen (
        .clock (clock),
        .rst   (rst)
    );

    stage_ex u_stage_ex (
        .clock      (clock),
        .rst        (rst),
        .issue      (issue),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (dmem_req),
        .complete   (complete)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // scrambled memory contents that depend on every address bit
    function automatic xlen_t mem_data(input xlen_t addr);
        return (addr * 32'h9e3779b1) ^ {addr[7:0], addr[31:8]} ^ 32'hc3a55a3c;
    endfunction

    assign dmem_rdata = mem_data(dmem_req.addr);

    function automatic fu_result_t ref_common(input issue_pkt_t p, input xlen_t value);
        fu_result_t r;
        r = '0;
        r.valid      = p.valid;
        r.result     = value;
        r.write_en   = p.valid && !p.illegal && (p.dest_tag != 0);
        r.write_tag  = p.dest_tag;
        r.write_data = value;
        r.remove_en  = p.valid && !p.illegal;
        r.rs_idx     = p.rs_idx;
        r.rob_idx    = p.rob_idx;
        return r;
    endfunction

    function automatic fu_result_t ref_alu(input issue_pkt_t p);
        xlen_t v;
        v = ALU_FILLER;
        if (p.alu_func == ALU_ADD) v = p.opa + p.opb;
        if (p.alu_func == ALU_SUB) v = p.opa - p.opb;
        if (p.alu_func == ALU_AND) v = p.opa & p.opb;
        if (p.alu_func == ALU_OR) v = p.opa | p.opb;
        if (p.alu_func == ALU_XOR) v = p.opa ^ p.opb;
        if (p.alu_func == ALU_SLT) v = {31'b0, $signed(p.opa) < $signed(p.opb)};
        if (p.alu_func == ALU_SLTU) v = {31'b0, p.opa < p.opb};
        if (p.alu_func == ALU_SLL) v = p.opa << p.opb[4:0];
        if (p.alu_func == ALU_SRL) v = p.opa >> p.opb[4:0];
        if (p.alu_func == ALU_SRA) v = $signed(p.opa) >>> p.opb[4:0];
        return ref_common(p, v);
    endfunction

    function automatic fu_result_t ref_branch(input issue_pkt_t p);
        fu_result_t r;
        logic       cond;
        logic       redirect;
        logic       live;
        xlen_t      v;
        case (p.funct3)
            3'd0: cond = p.rs1_value == p.rs2_value;
            3'd1: cond = p.rs1_value != p.rs2_value;
            3'd4: cond = $signed(p.rs1_value) < $signed(p.rs2_value);
            3'd5: cond = !($signed(p.rs1_value) < $signed(p.rs2_value));
            3'd6: cond = p.rs1_value < p.rs2_value;
            3'd7: cond = !(p.rs1_value < p.rs2_value);
            default: cond = 1'b0;
        endcase
        live = p.valid && !p.illegal;
        redirect = p.uncond_branch || (p.cond_branch && (cond != p.pred_take));
        v = (p.cond_branch && p.pred_take && !cond) ? p.npc : p.opa + p.opb;
        r = ref_common(p, v);
        if (redirect) r.write_data = p.npc;
        r.remove_en   = live && !redirect;
        r.take_branch = redirect;
        r.cond_take   = live && cond;
        r.bp_enable   = live && p.cond_branch;
        return r;
    endfunction

    function automatic fu_result_t ref_load(input issue_pkt_t p, input xlen_t rdata);
        fu_result_t r;
        xlen_t      ext;
        ext = rdata;
        if (p.funct3[1:0] == 2'd0) begin
            ext = p.funct3[2] ? {24'b0, rdata[7:0]} : {{24{rdata[7]}}, rdata[7:0]};
        end
        if (p.funct3[1:0] == 2'd1) begin
            ext = p.funct3[2] ? {16'b0, rdata[15:0]} : {{16{rdata[15]}}, rdata[15:0]};
        end
        r = ref_common(p, p.rd_mem ? ext : p.opa + p.opb);
        r.remove_en = r.remove_en && p.rd_mem;
        return r;
    endfunction

    function automatic complete_t ref_complete(input issue_vec_t iv, input xlen_t rdata);
        complete_t  c;
        fu_result_t r [NUM_SLOTS];
        c = '0;
        r[SLOT_LOAD]   = ref_load(iv[SLOT_LOAD], rdata);
        r[SLOT_BRANCH] = ref_branch(iv[SLOT_BRANCH]);
        for (int s = SLOT_ALU_LO; s < NUM_SLOTS; s++) begin
            r[s] = ref_alu(iv[s]);
        end
        // first valid slot counting up wins
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (r[s].valid && !c.fu.valid) begin
                c.fu   = r[s];
                c.slot = slot_idx_t'(s);
            end
        end
        return c;
    endfunction

    function automatic dmem_req_t ref_req(input issue_pkt_t p);
        dmem_req_t q;
        q.cmd  = (p.valid && p.rd_mem) ? BUS_LOAD : BUS_NONE;
        q.size = mem_size_e'(p.funct3[1:0]);
        q.addr = p.opa + p.opb;
        return q;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        assert (got === exp)
            else begin
                errors++;
                $display("mismatch %s: got %0h expected %0h", name, got, exp);
            end
    endtask

    task automatic compare_complete(input complete_t e);
        check_val("complete.slot", complete.slot, e.slot);
        check_val("complete.valid", complete.fu.valid, e.fu.valid);
        check_val("complete.result", complete.fu.result, e.fu.result);
        check_val("complete.write_en", complete.fu.write_en, e.fu.write_en);
        check_val("complete.write_tag", complete.fu.write_tag, e.fu.write_tag);
        check_val("complete.write_data", complete.fu.write_data, e.fu.write_data);
        check_val("complete.remove_en", complete.fu.remove_en, e.fu.remove_en);
        check_val("complete.rs_idx", complete.fu.rs_idx, e.fu.rs_idx);
        check_val("complete.rob_idx", complete.fu.rob_idx, e.fu.rob_idx);
        check_val("complete.take_branch", complete.fu.take_branch, e.fu.take_branch);
        check_val("complete.cond_take", complete.fu.cond_take, e.fu.cond_take);
        check_val("complete.bp_enable", complete.fu.bp_enable, e.fu.bp_enable);
    endtask

    // complete lags issue by one edge while dmem_req follows issue directly
    always @(posedge clock) begin
        dmem_req_t req_exp;
        if (have_exp) begin
            compare_complete(exp_prev);
            checked++;
        end
        req_exp = ref_req(issue[SLOT_LOAD]);
        check_val("dmem_req.cmd", dmem_req.cmd, req_exp.cmd);
        check_val("dmem_req.size", dmem_req.size, req_exp.size);
        check_val("dmem_req.addr", dmem_req.addr, req_exp.addr);
        if (rst) begin
            exp_prev = '0;
        end else begin
            exp_prev = ref_complete(issue,
                mem_data(issue[SLOT_LOAD].opa + issue[SLOT_LOAD].opb));
        end
        have_exp = 1'b1;
    end

    task automatic drive(input issue_vec_t v);
        @(negedge clock);
        issue = v;
    endtask

    task automatic rand_pkt(output issue_pkt_t p);
        logic [31:0] r;
        p = '0;
        p.valid = 1'b1;
        rand_bits(32, r);
        p.opa = r;
        rand_bits(32, r);
        p.opb = r;
        rand_bits(32, r);
        p.rs1_value = r;
        rand_bits(32, r);
        p.rs2_value = r;
        rand_bits(32, r);
        p.npc = r;
        rand_bits(4, r);
        p.alu_func = alu_func_e'(r[3:0] % 4'd10);
        rand_bits(3, r);
        p.funct3 = r[2:0];
        rand_bits(4, r);
        p.rd_mem        = r[0];
        p.cond_branch   = r[1];
        p.uncond_branch = r[2];
        p.pred_take     = r[3];
        rand_bits(13, r);
        p.dest_tag = r[5:0];
        p.rs_idx   = r[7:6];
        p.rob_idx  = r[12:8];
    endtask

    task automatic run_alu();
        issue_vec_t v;
        issue_pkt_t p;
        for (int f = 0; f < 10; f++) begin
            for (int k = 0; k < 6; k++) begin
                rand_pkt(p);
                p.alu_func = alu_func_e'(f);
                // tag 0 is the zero register
                if (k == 5) p.dest_tag = '0;
                v = '0;
                v[SLOT_ALU_LO + (k % 2)] = p;
                drive(v);
            end
        end
    endtask

    task automatic run_branch();
        issue_vec_t  v;
        issue_pkt_t  p;
        logic [31:0] r;
        for (int f = 0; f < 8; f++) begin
            for (int k = 0; k < 6; k++) begin
                rand_pkt(p);
                p.funct3 = funct3_t'(f);
                rand_bits(3, r);
                p.cond_branch   = !r[1];
                p.uncond_branch = r[1] && !r[0];
                // equal operands for the eq/ge cases
                if (r[2]) p.rs2_value = p.rs1_value;
                v = '0;
                v[SLOT_BRANCH] = p;
                drive(v);
            end
        end
    endtask

    task automatic run_load();
        issue_vec_t v;
        issue_pkt_t p;
        for (int sz = 0; sz < 3; sz++) begin
            for (int u = 0; u < 2; u++) begin
                for (int k = 0; k < 4; k++) begin
                    rand_pkt(p);
                    p.funct3 = {u[0], sz[1:0]};
                    p.rd_mem = 1'b1;
                    v = '0;
                    v[SLOT_LOAD] = p;
                    drive(v);
                end
            end
        end
        // address-only packets that must not release the entry
        for (int k = 0; k < 4; k++) begin
            rand_pkt(p);
            p.rd_mem = 1'b0;
            v = '0;
            v[SLOT_LOAD] = p;
            drive(v);
        end
    endtask

    task automatic run_priority();
        issue_vec_t  v;
        issue_pkt_t  p;
        logic [31:0] m;
        logic [31:0] r;
        for (int n = 0; n < 48; n++) begin
            rand_bits(NUM_SLOTS, m);
            if (n % 8 == 7) m = '0;
            for (int s = 0; s < NUM_SLOTS; s++) begin
                rand_pkt(p);
                p.valid = m[s];
                rand_bits(2, r);
                p.illegal = (r[1:0] == 2'd0);
                v[s] = p;
            end
            drive(v);
        end
    endtask

    task automatic wait_reset(output bit ok);
        int n;
        n = 0;
        while (rst && n < 40) begin
            @(posedge clock);
            n++;
        end
        ok = !rst;
        if (!ok) begin
            timeouts++;
            $display("timeout: reset was never released");
        end
    endtask

    task automatic drain(output bit ok);
        int target;
        int n;
        drive('0);
        target = checked + 3;
        n = 0;
        while (checked < target && n < 20) begin
            @(negedge clock);
            n++;
        end
        ok = (checked >= target);
        if (!ok) begin
            timeouts++;
            $display("timeout: last completions were never compared");
        end
    endtask

    initial begin
        bit         ok;
        issue_vec_t v;
        issue_pkt_t p;
        issue      = '0;
        lfsr_state = 32'h69312c0b;
        errors     = 0;
        checks     = 0;
        timeouts   = 0;
        checked    = 0;
        have_exp   = 1'b0;
        // live traffic during reset that must never complete
        for (int s = 0; s < NUM_SLOTS; s++) begin
            rand_pkt(p);
            v[s] = p;
        end
        issue = v;
        wait_reset(ok);
        if (ok) begin
            run_alu();
            run_branch();
            run_load();
            run_priority();
            drain(ok);
        end
        $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* sim.f */
hw/ex_pkg.sv
hw/alu_unit.sv
hw/branch_unit.sv
hw/load_unit.sv
hw/complete_select.sv
hw/stage_ex.sv
sim/tb_clock_gen.sv
sim/tb_stage_ex.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_stage_ex
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = NO ERRORS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
